// ==== dcache_config.svh ====
// ======================================================================
// data cache sizing: word, block, address, index and tag widths
// ======================================================================
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// word geometry
`define DWORD_SIZE 4
`define DWORD_SIZE_BITS 32

// block geometry
`define DBLOCK_SIZE_WORDS 4
`define DBLOCK_SIZE 16
`define DBLOCK_SIZE_BITS 128

// byte address split as tag | index | block offset
`define DADDR_SIZE 12
`define DBLOCK_OFFSET_SIZE 4
`define DINDEX_SIZE 4
`define DTAG_SIZE 4

// memory side addresses whole blocks
`define DMEM_BLOCK_ADDR_SIZE 8

`endif

// ==== dcachePkg.sv ====
// ======================================================================
// shared types of the data cache
// ======================================================================
`include "dcache_config.svh"

package dcachePkg;

	// pipeline side
	typedef logic [`DADDR_SIZE-1:0] addrT;
	typedef logic [`DWORD_SIZE_BITS-1:0] wordT;
	typedef logic [`DWORD_SIZE-1:0] byteSelT;

	// block and memory side
	typedef logic [`DBLOCK_SIZE_BITS-1:0] blockT;
	typedef logic [`DBLOCK_SIZE-1:0] blockMaskT;
	typedef logic [`DMEM_BLOCK_ADDR_SIZE-1:0] blockAddrT;

	// address fields
	typedef logic [`DTAG_SIZE-1:0] tagT;
	typedef logic [`DINDEX_SIZE-1:0] indexT;

	// miss handling sequence
	typedef enum logic [2:0] {
		idle,
		miss,
		writeBack,
		memRead,
		memCache
	} missStateT;

endpackage

// ==== cacheArrayIf.sv ====
// ======================================================================
// link between the miss controller and the tag and data stores
// ======================================================================
`timescale 1ns/1ns

interface cacheArrayIf;

	// lookup address, from the controller
	dcachePkg::indexT index;
	dcachePkg::tagT tag;

	// lookup results
	logic hit;
	logic dirty;
	dcachePkg::tagT victimTag;
	dcachePkg::blockT readBlock;

	// update controls, from the controller
	logic wordWrite;
	dcachePkg::blockMaskT byteMask;
	dcachePkg::blockT writeBlock;
	logic fill;

	modport control(output index, tag, wordWrite, byteMask, writeBlock, fill,
		input hit, dirty, victimTag, readBlock);

	modport tagSide(input index, tag, wordWrite, fill,
		output hit, dirty, victimTag);

	modport dataSide(input index, wordWrite, byteMask, writeBlock, fill,
		output readBlock);

endinterface

// ==== cacheTagStore.sv ====
// ======================================================================
// tag store: valid, dirty and tag per line, with hit and victim lookup
// ======================================================================
`timescale 1ns/1ns
`include "dcache_config.svh"

module cacheTagStore (
	input logic clock,
	input logic reset,
	cacheArrayIf.tagSide arrays
);

	localparam int lineCount = 1 << `DINDEX_SIZE;

	logic [lineCount-1:0] validBits;
	logic [lineCount-1:0] dirtyBits;
	dcachePkg::tagT tagArray [lineCount];

	dcachePkg::tagT storedTag;
	logic lineValid;

	// combinational lookup by index
	assign storedTag = tagArray[arrays.index];
	assign lineValid = validBits[arrays.index];

	assign arrays.hit = lineValid && (storedTag == arrays.tag);

	// an invalid line never needs a writeback
	assign arrays.dirty = lineValid && dirtyBits[arrays.index];
	assign arrays.victimTag = storedTag;

	// line state bits
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			validBits <= '0;
			dirtyBits <= '0;
		end else if (arrays.fill) begin
			// a refilled line matches memory
			validBits[arrays.index] <= 1'b1;
			dirtyBits[arrays.index] <= 1'b0;
		end else if (arrays.wordWrite) begin
			dirtyBits[arrays.index] <= 1'b1;
		end
	end

	// tags change only on refill
	always_ff @(posedge clock) begin
		if (arrays.fill) begin
			tagArray[arrays.index] <= arrays.tag;
		end
	end

	// store writes happen only while idle, refill only in memCache
	assert property (@(posedge clock) disable iff (!reset)
		!(arrays.wordWrite && arrays.fill))
	else $error("tag store: wordWrite and fill in the same cycle");

endmodule

// ==== cacheDataStore.sv ====
// ======================================================================
// data store: one block per line, byte-lane word writes and block refill
// ======================================================================
`timescale 1ns/1ns
`include "dcache_config.svh"

module cacheDataStore (
	input logic clock,
	cacheArrayIf.dataSide arrays
);

	localparam int lineCount = 1 << `DINDEX_SIZE;

	dcachePkg::blockT blocks [lineCount];

	// addressed line, read combinationally
	assign arrays.readBlock = blocks[arrays.index];

	always_ff @(posedge clock) begin
		if (arrays.fill) begin
			// whole block from memory
			blocks[arrays.index] <= arrays.writeBlock;
		end else if (arrays.wordWrite) begin
			// only the lanes picked by the mask
			for (int i = 0; i < `DBLOCK_SIZE; i++) begin
				if (arrays.byteMask[i]) begin
					blocks[arrays.index][i*8 +: 8] <= arrays.writeBlock[i*8 +: 8];
				end
			end
		end
	end

	// a store with no byte lanes would mark the line dirty for nothing
	assert property (@(posedge clock)
		arrays.wordWrite |-> (arrays.byteMask != '0))
	else $error("data store: wordWrite with an empty byte mask");

endmodule

// ==== cacheMissController.sv ====
// ======================================================================
// miss controller: request decode, word select, stall, and the miss FSM
// that writes back dirty victims and refills lines from memory
// ======================================================================
`timescale 1ns/1ns
`include "dcache_config.svh"

module cacheMissController (
	input logic clock,
	input logic reset,
	// pipeline side
	input logic ren,
	input logic wen,
	input dcachePkg::addrT addr,
	input dcachePkg::byteSelT byteSelect,
	input dcachePkg::wordT din,
	output logic stall,
	output dcachePkg::wordT dout,
	// memory side
	output logic memRen,
	output logic memWen,
	output dcachePkg::blockAddrT memBlockAddr,
	output dcachePkg::blockT memDin,
	input logic memReadReady,
	input logic memWriteDone,
	input dcachePkg::blockT memDout,
	// stores
	cacheArrayIf.control arrays
);

	localparam int wordOffsetBits = $clog2(`DBLOCK_SIZE_WORDS);
	localparam int byteOffsetBits = $clog2(`DWORD_SIZE);

	dcachePkg::missStateT state;
	dcachePkg::missStateT nextState;

	dcachePkg::tagT reqTag;
	dcachePkg::indexT reqIndex;
	logic [wordOffsetBits-1:0] wordOffset;
	logic request;

	dcachePkg::blockT laneBlock;
	dcachePkg::blockT fillBuffer;

	// exactly one of ren and wen
	assign request = ren ^ wen;

	// address fields
	assign reqTag = addr[`DADDR_SIZE-1 -: `DTAG_SIZE];
	assign reqIndex = addr[`DBLOCK_OFFSET_SIZE +: `DINDEX_SIZE];
	assign wordOffset = addr[byteOffsetBits +: wordOffsetBits];

	assign arrays.index = reqIndex;
	assign arrays.tag = reqTag;

	// read word out of the addressed block
	assign dout = arrays.readBlock[wordOffset*`DWORD_SIZE_BITS +: `DWORD_SIZE_BITS];

	// store data and byte lanes moved into the word's slot
	always_comb begin
		laneBlock = '0;
		laneBlock[wordOffset*`DWORD_SIZE_BITS +: `DWORD_SIZE_BITS] = din;
	end

	assign arrays.byteMask = dcachePkg::blockMaskT'(byteSelect) << (wordOffset * `DWORD_SIZE);

	// write hit commits at the next edge
	assign arrays.wordWrite = (state == dcachePkg::idle) && wen && !ren && arrays.hit;
	assign arrays.fill = (state == dcachePkg::memCache);
	assign arrays.writeBlock = arrays.fill ? fillBuffer : laneBlock;

	// hold the pipeline on a fresh miss and throughout miss handling
	assign stall = (state != dcachePkg::idle) || (request && !arrays.hit);

	// memory strobes are levels tied to the waiting states
	assign memWen = (state == dcachePkg::writeBack);
	assign memRen = (state == dcachePkg::memRead);

	// victim goes back to its own block address
	assign memBlockAddr = memWen ? {arrays.victimTag, reqIndex} : {reqTag, reqIndex};
	assign memDin = arrays.readBlock;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			state <= dcachePkg::idle;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			dcachePkg::idle: begin
				if (request && !arrays.hit) begin
					nextState = dcachePkg::miss;
				end
			end
			dcachePkg::miss: begin
				if (arrays.dirty) begin
					nextState = dcachePkg::writeBack;
				end else begin
					nextState = dcachePkg::memRead;
				end
			end
			dcachePkg::writeBack: begin
				if (memWriteDone) begin
					nextState = dcachePkg::memRead;
				end
			end
			dcachePkg::memRead: begin
				if (memReadReady) begin
					nextState = dcachePkg::memCache;
				end
			end
			dcachePkg::memCache: begin
				nextState = dcachePkg::idle;
			end
			default: nextState = dcachePkg::idle;
		endcase
	end

	// refill data, captured with the ready pulse
	always_ff @(posedge clock) begin
		if (memRen && memReadReady) begin
			fillBuffer <= memDout;
		end
	end

	assert property (@(posedge clock) disable iff (!reset)
		!(memRen && memWen))
	else $error("controller: memRen and memWen high together");

	assert property (@(posedge clock) disable iff (!reset)
		!(ren && wen))
	else $error("controller: ren and wen high together");

endmodule

// ==== dataCache.sv ====
// ======================================================================
// direct-mapped write-back data cache, top level
// ======================================================================
`timescale 1ns/1ns

module dataCache (
	input logic clock,
	input logic reset,
	// pipeline side
	input logic ren,
	input logic wen,
	input dcachePkg::addrT addr,
	input dcachePkg::byteSelT byteSelect,
	input dcachePkg::wordT din,
	output logic stall,
	output dcachePkg::wordT dout,
	// memory side
	output logic memRen,
	output logic memWen,
	output dcachePkg::blockAddrT memBlockAddr,
	output dcachePkg::blockT memDin,
	input logic memReadReady,
	input logic memWriteDone,
	input dcachePkg::blockT memDout
);

	cacheArrayIf arrays ();

	cacheTagStore tagStore (
		.clock (clock),
		.reset (reset),
		.arrays (arrays.tagSide)
	);

	cacheDataStore dataStore (
		.clock (clock),
		.arrays (arrays.dataSide)
	);

	cacheMissController controller (
		.clock (clock),
		.reset (reset),
		.ren (ren),
		.wen (wen),
		.addr (addr),
		.byteSelect (byteSelect),
		.din (din),
		.stall (stall),
		.dout (dout),
		.memRen (memRen),
		.memWen (memWen),
		.memBlockAddr (memBlockAddr),
		.memDin (memDin),
		.memReadReady (memReadReady),
		.memWriteDone (memWriteDone),
		.memDout (memDout),
		.arrays (arrays.control)
	);

endmodule

// ==== tbClock.sv ====
// ======================================================================
// testbench clock (4 ns period) and active-low reset for 10 cycles
// ======================================================================
`timescale 1ns/1ns

module tbClock (
	output logic clock,
	output logic reset
);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	initial begin
		reset = 1'b0;
		repeat (10) @(posedge clock);
		reset <= 1'b1;
	end

endmodule

// ==== dataCacheTb.sv ====
// ======================================================================
// data cache testbench: random loads and stores against a reference
// model, with a block memory that answers after random delays
// ======================================================================
`timescale 1ns/1ns
`include "dcache_config.svh"

module dataCacheTb;

	localparam int requestCount = 2000;
	localparam int requestLimit = 64;
	localparam int resetLimit = 100;
	localparam int byteCount = 1 << `DADDR_SIZE;
	localparam int blockCount = 1 << `DMEM_BLOCK_ADDR_SIZE;
	localparam int lineCount = 1 << `DINDEX_SIZE;

	logic clock;
	logic reset;
	logic ren;
	logic wen;
	dcachePkg::addrT addr;
	dcachePkg::byteSelT byteSelect;
	dcachePkg::wordT din;
	logic stall;
	dcachePkg::wordT dout;
	logic memRen;
	logic memWen;
	dcachePkg::blockAddrT memBlockAddr;
	dcachePkg::blockT memDin;
	logic memReadReady;
	logic memWriteDone;
	dcachePkg::blockT memDout;

	logic [31:0] lfsrState;

	// coherent byte view, block memory, and shadow of the line state
	logic [7:0] refBytes [byteCount];
	dcachePkg::blockT memBlocks [blockCount];
	dcachePkg::tagT shadowTag [lineCount];
	logic shadowValid [lineCount];
	logic shadowDirty [lineCount];

	tbClock clockGen (
		.clock (clock),
		.reset (reset)
	);

	dataCache uut (
		.clock (clock),
		.reset (reset),
		.ren (ren),
		.wen (wen),
		.addr (addr),
		.byteSelect (byteSelect),
		.din (din),
		.stall (stall),
		.dout (dout),
		.memRen (memRen),
		.memWen (memWen),
		.memBlockAddr (memBlockAddr),
		.memDin (memDin),
		.memReadReady (memReadReady),
		.memWriteDone (memWriteDone),
		.memDout (memDout)
	);

	// initial memory byte, a function of every address bit
	function automatic logic [7:0] fillByte(input dcachePkg::addrT a);
		return a[7:0] ^ {a[3:0], a[11:8]} ^ 8'ha5;
	endfunction

	// galois LFSR, one step per bit taken
	function automatic logic [31:0] takeBits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			value = {value[30:0], lfsrState[0]};
			if (lfsrState[0]) begin
				lfsrState = (lfsrState >> 1) ^ 32'h8020_0003;
			end else begin
				lfsrState = lfsrState >> 1;
			end
		end
		return value;
	endfunction

	function automatic dcachePkg::wordT refWord(input dcachePkg::addrT wordAddr);
		dcachePkg::wordT value;
		dcachePkg::addrT a;
		for (int k = 0; k < `DWORD_SIZE; k++) begin
			a = {wordAddr[`DADDR_SIZE-1:2], 2'(k)};
			value[k*8 +: 8] = refBytes[a];
		end
		return value;
	endfunction

	function automatic dcachePkg::blockT refBlock(input dcachePkg::blockAddrT b);
		dcachePkg::blockT value;
		dcachePkg::addrT a;
		for (int k = 0; k < `DBLOCK_SIZE; k++) begin
			a = {b, 4'(k)};
			value[k*8 +: 8] = refBytes[a];
		end
		return value;
	endfunction

	task automatic abortRun();
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic checkFlag(input string name, input logic got, input logic expected);
		if (got !== expected) begin
			$display("ERROR %s: got %h expected %h", name, got, expected);
			abortRun();
		end
	endtask

	task automatic checkWord(input string name, input dcachePkg::wordT got,
		input dcachePkg::wordT expected);
		if (got !== expected) begin
			$display("ERROR %s: got %h expected %h", name, got, expected);
			abortRun();
		end
	endtask

	task automatic checkBlock(input string name, input dcachePkg::blockT got,
		input dcachePkg::blockT expected);
		if (got !== expected) begin
			$display("ERROR %s: got %h expected %h", name, got, expected);
			abortRun();
		end
	endtask

	task automatic checkBlockAddr(input string name, input dcachePkg::blockAddrT got,
		input dcachePkg::blockAddrT expected);
		if (got !== expected) begin
			$display("ERROR %s: got %h expected %h", name, got, expected);
			abortRun();
		end
	endtask

	// writeback of a dirty victim, acknowledged after a random delay
	task automatic serveWrite(input dcachePkg::blockAddrT victimAddr);
		int delay;
		checkBlockAddr("memBlockAddr", memBlockAddr, victimAddr);
		checkBlock("memDin", memDin, refBlock(victimAddr));
		memBlocks[victimAddr] = memDin;
		delay = int'(takeBits(3));
		for (int i = 0; i < delay; i++) begin
			@(negedge clock);
			checkFlag("memWen", memWen, 1'b1);
			checkFlag("memRen", memRen, 1'b0);
			checkFlag("stall", stall, 1'b1);
			checkBlockAddr("memBlockAddr", memBlockAddr, victimAddr);
			checkBlock("memDin", memDin, refBlock(victimAddr));
		end
		@(posedge clock);
		memWriteDone <= 1'b1;
		@(posedge clock);
		memWriteDone <= 1'b0;
		@(negedge clock);
	endtask

	// refill read, answered after a random delay
	task automatic serveRead(input dcachePkg::blockAddrT blockAddr);
		int delay;
		checkBlockAddr("memBlockAddr", memBlockAddr, blockAddr);
		delay = int'(takeBits(3));
		for (int i = 0; i < delay; i++) begin
			@(negedge clock);
			checkFlag("memRen", memRen, 1'b1);
			checkFlag("memWen", memWen, 1'b0);
			checkFlag("stall", stall, 1'b1);
			checkBlockAddr("memBlockAddr", memBlockAddr, blockAddr);
		end
		@(posedge clock);
		memReadReady <= 1'b1;
		memDout <= memBlocks[blockAddr];
		@(posedge clock);
		memReadReady <= 1'b0;
		@(negedge clock);
	endtask

	task automatic runRequest();
		logic isWrite;
		dcachePkg::tagT tag;
		dcachePkg::indexT idx;
		logic [1:0] wordSel;
		dcachePkg::byteSelT sel;
		dcachePkg::wordT data;
		dcachePkg::addrT reqAddr;
		dcachePkg::addrT a;
		logic expectMiss;
		logic victimDirty;
		logic sawWrite;
		logic refilled;
		logic done;
		int cycles;

		isWrite = (takeBits(1) != 0);
		// only four tags, so conflicts and evictions are common
		tag = dcachePkg::tagT'(takeBits(2));
		idx = dcachePkg::indexT'(takeBits(4));
		wordSel = 2'(takeBits(2));
		sel = dcachePkg::byteSelT'(takeBits(4));
		data = takeBits(32);
		if (sel == '0) begin
			sel = 4'hf;
		end
		reqAddr = {tag, idx, wordSel, 2'b00};

		@(posedge clock);
		ren <= !isWrite;
		wen <= isWrite;
		addr <= reqAddr;
		byteSelect <= sel;
		din <= data;

		@(negedge clock);
		expectMiss = !(shadowValid[idx] && shadowTag[idx] == tag);
		victimDirty = shadowValid[idx] && shadowDirty[idx];
		checkFlag("stall", stall, expectMiss);
		sawWrite = 1'b0;
		refilled = 1'b0;
		done = 1'b0;
		cycles = 0;
		while (!done) begin
			checkFlag("memRen & memWen", memRen & memWen, 1'b0);
			if (!stall) begin
				if (expectMiss && !refilled) begin
					$display("a missing request completed without a refill");
					abortRun();
				end
				if (isWrite) begin
					for (int k = 0; k < `DWORD_SIZE; k++) begin
						a = {reqAddr[`DADDR_SIZE-1:2], 2'(k)};
						if (sel[k]) begin
							refBytes[a] = data[k*8 +: 8];
						end
					end
					shadowDirty[idx] = 1'b1;
				end else begin
					checkWord("dout", dout, refWord(reqAddr));
				end
				done = 1'b1;
			end else begin
				if (memWen) begin
					if (!victimDirty) begin
						$display("memory write started on a miss with a clean victim");
						abortRun();
					end
					serveWrite({shadowTag[idx], idx});
					sawWrite = 1'b1;
				end else if (memRen) begin
					if (victimDirty && !sawWrite) begin
						$display("memory read started before the dirty victim was written back");
						abortRun();
					end
					serveRead({tag, idx});
					shadowTag[idx] = tag;
					shadowValid[idx] = 1'b1;
					shadowDirty[idx] = 1'b0;
					refilled = 1'b1;
				end else begin
					@(negedge clock);
				end
				cycles++;
				if (cycles > requestLimit) begin
					$display("request did not complete within %0d cycles", requestLimit);
					abortRun();
				end
			end
		end
	endtask

	initial begin
		dcachePkg::addrT a;
		dcachePkg::blockAddrT b;
		dcachePkg::indexT n;
		int waitCycles;

		lfsrState = 32'hb21c_0a21;
		ren = 1'b0;
		wen = 1'b0;
		addr = '0;
		byteSelect = '0;
		din = '0;
		memReadReady = 1'b0;
		memWriteDone = 1'b0;
		memDout = '0;
		for (int i = 0; i < byteCount; i++) begin
			a = dcachePkg::addrT'(i);
			refBytes[a] = fillByte(a);
		end
		for (int i = 0; i < blockCount; i++) begin
			b = dcachePkg::blockAddrT'(i);
			memBlocks[b] = refBlock(b);
		end
		for (int i = 0; i < lineCount; i++) begin
			n = dcachePkg::indexT'(i);
			shadowTag[n] = '0;
			shadowValid[n] = 1'b0;
			shadowDirty[n] = 1'b0;
		end

		waitCycles = 0;
		while (reset !== 1'b1) begin
			@(posedge clock);
			waitCycles++;
			if (waitCycles > resetLimit) begin
				$display("reset was not released within %0d cycles", resetLimit);
				abortRun();
			end
		end

		// quiet outputs out of reset
		@(negedge clock);
		checkFlag("stall", stall, 1'b0);
		checkFlag("memRen", memRen, 1'b0);
		checkFlag("memWen", memWen, 1'b0);

		for (int r = 0; r < requestCount; r++) begin
			runRequest();
		end

		@(posedge clock);
		ren <= 1'b0;
		wen <= 1'b0;
		@(negedge clock);
		checkFlag("stall", stall, 1'b0);

		$display("STATUS: PASS");
		$finish;
	end

endmodule

// ==== filelist.f ====
+incdir+.
dcachePkg.sv
cacheArrayIf.sv
cacheTagStore.sv
cacheDataStore.sv
cacheMissController.sv
dataCache.sv
tbClock.sv
dataCacheTb.sv

// ==== run.sh ====
#!/bin/sh
# build the data cache testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f filelist.f --top-module dataCacheTb -o dataCacheSim \
	&& ./obj_dir/dataCacheSim \
	|| exit 1
